// ==== include/board_config.svh ====
// board configuration constants
// address spaces, channel-0 register map, hub layout and watchdog timing
// shared by the register-bus core of the motor controller board

`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// ------------------------------------------------------------------------
// address spaces, carried in reg_addr[15:12]
// ------------------------------------------------------------------------
`define ADDR_MAIN           4'h0    // board and per-channel registers
`define ADDR_HUB            4'h2    // hub quadlet memory

// channel-0 register offsets, reg_addr[3:0]
`define REG_STATUS          4'd0    // board id and timeout flag
`define REG_VERSION         4'd1    // firmware version
`define REG_WDOG            4'd3    // watchdog period

// per-channel offsets used by the real-time block read
`define REG_ADC             4'd0    // motor adc quadlet
`define REG_MOTOR_STATUS    4'd1    // motor status quadlet
`define REG_ENC_BASE        4'd4    // first of five encoder quadlets

// channel counts
`define NUM_MOTORS          4
`define NUM_ENCODERS        4

// ------------------------------------------------------------------------
// hub memory and misc
// ------------------------------------------------------------------------
`define HUB_DEPTH           64      // quadlets
`define HUB_SEQ_OFFSET      12'h800 // broadcast sequence register

`define FW_VERSION          32'h0001_0008
`define WDOG_TICK           16      // sysclk cycles per watchdog count

// quadlets in one real-time block read, header and crc excluded
`define NUM_RT_READ_QUADS   (4 + 2 * `NUM_MOTORS + 5 * `NUM_ENCODERS)

`endif

// ==== design/board_pkg.sv ====
// board package
// bus and watchdog types shared by the register-bus core

package board_pkg;

    // register bus address
    // [15:12] space, [7:4] channel, [3:0] register
    typedef logic [15:0] reg_addr_t;

    // one quadlet of read or write data
    typedef logic [31:0] reg_data_t;

    // rotary switch value
    typedef logic [3:0]  board_id_t;

    // quadlet index inside a real-time block read
    typedef logic [7:0]  quad_idx_t;

    // host watchdog states
    typedef enum logic [1:0] {
        WDOG_OFF,       // period is zero, nothing counts
        WDOG_RUN,       // counting ticks since the last write
        WDOG_EXPIRED    // timeout flag held
    } wdog_state_t;

endpackage

// ==== design/rt_read_xlate.sv ====
// real-time block read address translation
// turns a quadlet index into main, motor or encoder register addresses
// while a real-time block read is in progress, passes the address otherwise

`timescale 1ns/1ps
`include "board_config.svh"

module rt_read_xlate (
    input  board_pkg::reg_addr_t reg_raddr_in,   // host read address
    input  logic                 blk_rt_rd,      // real-time block read active
    output board_pkg::reg_addr_t reg_raddr_out   // address onto the register bus
);
    import board_pkg::*;

    // section boundaries inside the block
    localparam quad_idx_t MOTOR_FIRST = quad_idx_t'(4);
    localparam quad_idx_t ENC_FIRST   = quad_idx_t'(4 + 2 * `NUM_MOTORS);
    localparam quad_idx_t BLK_END     = quad_idx_t'(`NUM_RT_READ_QUADS);

    quad_idx_t q;   // quadlet index from the host
    quad_idx_t j;   // index within the motor section
    quad_idx_t k;   // index within the encoder section

    assign q = reg_raddr_in[7:0];
    assign j = q - MOTOR_FIRST;
    assign k = q - ENC_FIRST;

    always_comb begin
        if (!blk_rt_rd) begin
            reg_raddr_out = reg_raddr_in;                       // normal read
        end else if (q < MOTOR_FIRST) begin
            // board registers, channel 0
            reg_raddr_out = {`ADDR_MAIN, 8'h00, q[3:0]};
        end else if (q < ENC_FIRST) begin
            // two quadlets per motor, channels start at 1
            reg_raddr_out = {`ADDR_MAIN, 4'h0, 4'(j / 8'd2) + 4'd1,
                             j[0] ? `REG_MOTOR_STATUS : `REG_ADC};
        end else if (q < BLK_END) begin
            // five quadlets per encoder
            reg_raddr_out = {`ADDR_MAIN, 4'h0, 4'(k / 8'd5) + 4'd1,
                             `REG_ENC_BASE + 4'(k % 8'd5)};
        end else begin
            reg_raddr_out = '0;                                 // past the block
        end
    end

endmodule

// ==== design/hub_mem.sv ====
// hub memory
// quadlet store for data gathered from other boards, plus the broadcast
// sequence register; reads come back registered one sysclk later

`timescale 1ns/1ps
`include "board_config.svh"

module hub_mem (
    input  logic                 sysclk,
    input  logic                 rst_n,
    input  board_pkg::reg_addr_t reg_raddr,
    input  board_pkg::reg_addr_t reg_waddr,
    input  board_pkg::reg_data_t reg_wdata,
    input  logic                 reg_wen,
    input  board_pkg::board_id_t board_id,
    output board_pkg::reg_data_t hub_rdata,   // valid one clock after raddr
    output logic [15:0]          hub_seq      // broadcast sequence number
);
    import board_pkg::*;

    localparam int HUB_AW = $clog2(`HUB_DEPTH);

    reg_data_t         mem [`HUB_DEPTH];  // hub quadlets
    logic              hub_wr;            // write into hub space
    logic              seq_wr;            // write hits the sequence register
    logic              seq_rd;            // read of the sequence register
    logic [HUB_AW-1:0] wr_idx;
    logic [HUB_AW-1:0] rd_idx;

    assign hub_wr = reg_wen && (reg_waddr[15:12] == `ADDR_HUB);
    assign seq_wr = hub_wr && (reg_waddr[11:0] == `HUB_SEQ_OFFSET);
    assign seq_rd = (reg_raddr[11:0] == `HUB_SEQ_OFFSET);
    assign wr_idx = reg_waddr[HUB_AW-1:0];              // addr mod depth
    assign rd_idx = reg_raddr[HUB_AW-1:0];

    // ------------------------------------------------------------------------
    // broadcast sequence register
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            hub_seq <= '0;
        end else if (seq_wr) begin
            hub_seq <= reg_wdata[15:0];                 // low half only
        end
    end

    // ------------------------------------------------------------------------
    // quadlet memory, write and registered read
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (hub_wr && !seq_wr) begin
            mem[wr_idx] <= reg_wdata;
        end
    end

    // sequence read returns the board id next to the sequence
    always_ff @(posedge sysclk) begin
        if (seq_rd) begin
            hub_rdata <= {12'h000, board_id, hub_seq};
        end else begin
            hub_rdata <= mem[rd_idx];                   // old data on collision
        end
    end

endmodule

// ==== design/board_regs.sv ====
// channel-0 board registers
// status, firmware version and watchdog period, plus the host watchdog
// that raises a timeout when the bus has been idle for the set period

`timescale 1ns/1ps
`include "board_config.svh"

module board_regs (
    input  logic                 sysclk,
    input  logic                 rst_n,
    input  board_pkg::reg_addr_t reg_raddr,
    input  board_pkg::reg_addr_t reg_waddr,
    input  board_pkg::reg_data_t reg_wdata,
    input  logic                 reg_wen,
    input  board_pkg::board_id_t board_id,
    input  logic                 wdog_clear,          // clear a pending timeout
    output board_pkg::reg_data_t regs_rdata,          // combinational read data
    output logic                 wdog_period_led,     // period is nonzero
    output logic                 wdog_timeout,
    output logic [2:0]           wdog_period_status   // coarse period for the led
);
    import board_pkg::*;

    localparam int TICK_W = $clog2(`WDOG_TICK);

    wdog_state_t       state;
    logic [15:0]       wdog_period;     // in ticks of WDOG_TICK sysclk
    logic [15:0]       period_next;     // period as it will be after this edge
    logic [15:0]       wdog_cnt;        // ticks since the last write
    logic [TICK_W-1:0] tick_cnt;        // sysclk within one tick
    logic              tick_wrap;
    logic              chan0_wr;
    logic              period_wr;
    logic              status_clr;      // status write with bit 0 set
    logic [10:0]       period_div;      // period / 32

    assign chan0_wr   = reg_wen && (reg_waddr[15:12] == `ADDR_MAIN) &&
                        (reg_waddr[7:4] == 4'd0);
    assign period_wr  = chan0_wr && (reg_waddr[3:0] == `REG_WDOG);
    assign status_clr = chan0_wr && (reg_waddr[3:0] == `REG_STATUS) && reg_wdata[0];
    assign period_next = period_wr ? reg_wdata[15:0] : wdog_period;
    assign tick_wrap  = (tick_cnt == TICK_W'(`WDOG_TICK - 1));

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_period <= '0;
        end else if (period_wr) begin
            wdog_period <= reg_wdata[15:0];
        end
    end

    // ------------------------------------------------------------------------
    // watchdog FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state    <= WDOG_OFF;
            tick_cnt <= '0;
            wdog_cnt <= '0;
        end else begin
            case (state)
                WDOG_OFF: begin
                    if (reg_wen && (period_next != 16'd0)) begin
                        state    <= WDOG_RUN;               // armed by a write
                        tick_cnt <= '0;
                        wdog_cnt <= '0;
                    end
                end
                WDOG_RUN: begin
                    if (reg_wen) begin
                        // any bus write restarts the count
                        state    <= (period_next != 16'd0) ? WDOG_RUN : WDOG_OFF;
                        tick_cnt <= '0;
                        wdog_cnt <= '0;
                    end else begin
                        tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
                        if (tick_wrap) begin
                            wdog_cnt <= wdog_cnt + 16'd1;
                            if (wdog_cnt + 16'd1 == wdog_period) begin
                                state <= WDOG_EXPIRED;      // host went quiet
                            end
                        end
                    end
                end
                WDOG_EXPIRED: begin
                    if (wdog_clear || status_clr) begin
                        state    <= (period_next != 16'd0) ? WDOG_RUN : WDOG_OFF;
                        tick_cnt <= '0;
                        wdog_cnt <= '0;
                    end
                end
                default: state <= WDOG_OFF;
            endcase
        end
    end

    assign wdog_timeout    = (state == WDOG_EXPIRED);
    assign wdog_period_led = |wdog_period;
    assign period_div      = wdog_period[15:5];

    // period / 32, held within 1..7 once nonzero
    always_comb begin
        if (wdog_period == 16'd0)      wdog_period_status = 3'd0;
        else if (period_div == 11'd0)  wdog_period_status = 3'd1;
        else if (period_div > 11'd7)   wdog_period_status = 3'd7;
        else                           wdog_period_status = period_div[2:0];
    end

    // ------------------------------------------------------------------------
    // read mux, offset only (channel decode lives in the router)
    // ------------------------------------------------------------------------
    always_comb begin
        case (reg_raddr[3:0])
            `REG_STATUS:  regs_rdata = {4'h0, board_id, 23'd0, wdog_timeout};
            `REG_VERSION: regs_rdata = `FW_VERSION;
            `REG_WDOG:    regs_rdata = {16'h0000, wdog_period};
            default:      regs_rdata = '0;
        endcase
    end

endmodule

// ==== design/read_route.sv ====
// read data routing
// picks hub or board-register data by read address and merges in the
// external board's data and wait flag

`timescale 1ns/1ps
`include "board_config.svh"

module read_route (
    input  board_pkg::reg_addr_t reg_raddr,
    input  board_pkg::reg_data_t hub_rdata,       // registered hub read
    input  board_pkg::reg_data_t regs_rdata,      // channel-0 registers
    input  board_pkg::reg_data_t reg_rdata_ext,   // external board data
    input  logic                 reg_rwait_ext,   // external board wait
    output board_pkg::reg_data_t reg_rdata,
    output logic                 reg_rwait        // 1 -> data one clock later
);
    import board_pkg::*;

    reg_data_t sel_data;    // internal source after decode
    logic      sel_wait;
    logic      is_hub;
    logic      is_chan0;    // main space, channel 0

    assign is_hub   = (reg_raddr[15:12] == `ADDR_HUB);
    assign is_chan0 = (reg_raddr[15:12] == `ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------
    always_comb begin
        sel_data = '0;
        sel_wait = 1'b0;
        if (is_hub) begin
            sel_data = hub_rdata;
            sel_wait = 1'b1;                // memory read, one clock late
        end else if (is_chan0) begin
            sel_data = regs_rdata;          // same-cycle register read
        end
    end

    // external board drives zero when not addressed
    assign reg_rdata = sel_data | reg_rdata_ext;
    assign reg_rwait = sel_wait | reg_rwait_ext;

endmodule

// ==== design/board_core.sv ====
// register-bus core of the motor controller board
// host port in, external register bus out, with read address translation,
// hub memory, board registers and read data routing

`timescale 1ns/1ps

module board_core (
    input  logic                 sysclk,
    input  logic                 rst_n,
    input  board_pkg::board_id_t board_id,          // rotary switch

    // host port
    input  board_pkg::reg_addr_t host_raddr,
    input  logic                 host_blk_rt_rd,    // raddr[7:0] is a quadlet index
    input  board_pkg::reg_addr_t host_waddr,
    input  board_pkg::reg_data_t host_wdata,
    input  logic                 host_wen,          // one-cycle write strobe
    input  logic                 host_blk_wen,
    input  logic                 host_blk_wstart,

    // external register bus
    output board_pkg::reg_addr_t reg_raddr,
    output board_pkg::reg_addr_t reg_waddr,
    output board_pkg::reg_data_t reg_wdata,
    output logic                 reg_wen,
    output logic                 blk_wen,
    output logic                 blk_wstart,
    input  board_pkg::reg_data_t reg_rdata_ext,
    input  logic                 reg_rwait_ext,

    // read result and hub sequence
    output board_pkg::reg_data_t reg_rdata,
    output logic                 reg_rwait,
    output logic [15:0]          hub_seq,

    // watchdog
    input  logic                 wdog_clear,
    output logic                 wdog_period_led,
    output logic [2:0]           wdog_period_status,
    output logic                 wdog_timeout
);
    import board_pkg::*;

    reg_data_t hub_rdata;   // hub memory read data
    reg_data_t regs_rdata;  // board register read data

    // ------------------------------------------------------------------------
    // write bus, single master so no arbitration
    // ------------------------------------------------------------------------
    assign reg_waddr  = host_waddr;
    assign reg_wdata  = host_wdata;
    assign reg_wen    = host_wen;
    assign blk_wen    = host_blk_wen;
    assign blk_wstart = host_blk_wstart;

    rt_read_xlate u_xlate (
        .reg_raddr_in  (host_raddr),
        .blk_rt_rd     (host_blk_rt_rd),
        .reg_raddr_out (reg_raddr)
    );

    hub_mem u_hub (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_raddr (reg_raddr),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .board_id  (board_id),
        .hub_rdata (hub_rdata),
        .hub_seq   (hub_seq)
    );

    board_regs u_chan0 (
        .sysclk             (sysclk),
        .rst_n              (rst_n),
        .reg_raddr          (reg_raddr),
        .reg_waddr          (reg_waddr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .board_id           (board_id),
        .wdog_clear         (wdog_clear),
        .regs_rdata         (regs_rdata),
        .wdog_period_led    (wdog_period_led),
        .wdog_timeout       (wdog_timeout),
        .wdog_period_status (wdog_period_status)
    );

    read_route u_route (
        .reg_raddr     (reg_raddr),
        .hub_rdata     (hub_rdata),
        .regs_rdata    (regs_rdata),
        .reg_rdata_ext (reg_rdata_ext),
        .reg_rwait_ext (reg_rwait_ext),
        .reg_rdata     (reg_rdata),
        .reg_rwait     (reg_rwait)
    );

endmodule

// ==== sim/board_checker.sv ====
// board_core checker
// reference model of the register bus, hub and watchdog, compared with the
// DUT ports on every falling edge

`timescale 1ns/1ps
`include "board_config.svh"

module board_checker (
    input  logic                 sysclk,
    input  logic                 rst_n,
    input  logic                 done,                  // stimulus finished
    input  board_pkg::board_id_t board_id,
    input  board_pkg::reg_addr_t host_raddr, host_waddr, reg_raddr, reg_waddr,
    input  board_pkg::reg_data_t host_wdata, reg_wdata, reg_rdata_ext, reg_rdata,
    input  logic                 host_blk_rt_rd, host_wen, host_blk_wen, host_blk_wstart,
    input  logic                 reg_rwait_ext, wdog_clear, reg_wen, blk_wen, blk_wstart,
    input  logic                 reg_rwait, wdog_period_led, wdog_timeout,
    input  logic [15:0]          hub_seq,
    input  logic [2:0]           wdog_period_status,
    output int                   errors
);
    import board_pkg::*;

    localparam int HUB_AW = $clog2(`HUB_DEPTH);

    reg_data_t   mem [`HUB_DEPTH];  // unknown until written
    reg_data_t   hub_q;             // hub read register as it should be
    reg_addr_t   raddr_q;           // read address seen at the last edge
    reg_addr_t   exp_raddr;
    logic [15:0] seq;
    logic [15:0] period;
    logic [15:0] period_nxt;
    logic        wr_chan0;          // host write to main space, channel 0
    logic        tmo;               // expected timeout flag
    logic        armed;
    int          idle;              // cycles since the restarting write
    int          err_cnt   = 0;
    int          fires     = 0;
    logic        tmo_q     = 1'b0;
    logic        done_seen = 1'b0;

    // quadlet index to register address, per the block-read layout
    function automatic reg_addr_t map_rt(input reg_addr_t a, input logic rt);
        int q;
        int j;
        q = int'(a[7:0]);
        if (!rt) return a;
        if (q < 4) return reg_addr_t'(q);                       // channel 0
        j = q - 4;
        if (j < 2 * `NUM_MOTORS) return reg_addr_t'(((j / 2 + 1) << 4) + j % 2);
        j = j - 2 * `NUM_MOTORS;
        if (j < 5 * `NUM_ENCODERS) begin
            return reg_addr_t'(((j / 5 + 1) << 4) + int'(`REG_ENC_BASE) + j % 5);
        end
        return '0;                                              // past the block
    endfunction

    function automatic reg_data_t regs_value(input reg_addr_t a);
        case (a[3:0])
            `REG_STATUS:  return {4'h0, board_id, 23'd0, tmo};
            `REG_VERSION: return `FW_VERSION;
            `REG_WDOG:    return {16'h0000, period};
            default:      return '0;
        endcase
    endfunction

    // coarse period for the led, period / 32 held in 1..7
    function automatic logic [2:0] status_of(input logic [15:0] p);
        int d;
        d = int'(p) / 32;
        if (p == 16'd0) return 3'd0;
        if (d < 1) return 3'd1;
        if (d > 7) return 3'd7;
        return 3'(d);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    assign errors     = err_cnt;
    assign exp_raddr  = map_rt(host_raddr, host_blk_rt_rd);
    assign wr_chan0   = host_wen && (host_waddr[15:12] == `ADDR_MAIN) &&
                        (host_waddr[7:4] == 4'd0);
    assign period_nxt = (wr_chan0 && host_waddr[3:0] == `REG_WDOG) ? host_wdata[15:0] : period;

    // ------------------------------------------------------------------------
    // model state, updated on the rising edge
    // ------------------------------------------------------------------------
    always @(posedge sysclk) begin
        raddr_q <= exp_raddr;
        if (exp_raddr[11:0] == `HUB_SEQ_OFFSET) begin
            hub_q <= {12'h000, board_id, seq};
        end else begin
            hub_q <= mem[exp_raddr[HUB_AW-1:0]];              // read before write
        end
        if (host_wen && host_waddr[15:12] == `ADDR_HUB && host_waddr[11:0] != `HUB_SEQ_OFFSET) begin
            mem[host_waddr[HUB_AW-1:0]] <= host_wdata;
        end
        if (!rst_n) begin
            seq    <= '0;
            period <= '0;
            tmo    <= 1'b0;
            armed  <= 1'b0;
            idle   <= 0;
        end else begin
            if (host_wen && host_waddr[15:12] == `ADDR_HUB &&
                host_waddr[11:0] == `HUB_SEQ_OFFSET) begin
                seq <= host_wdata[15:0];
            end
            period <= period_nxt;
            if (tmo) begin
                // writes do not restart an expired watchdog, only a clear does
                if (wdog_clear || (wr_chan0 && host_waddr[3:0] == `REG_STATUS &&
                    host_wdata[0])) begin
                    tmo   <= 1'b0;
                    idle  <= 0;
                    armed <= (period_nxt != 16'd0);
                end
            end else if (host_wen) begin
                idle  <= 0;
                armed <= (period_nxt != 16'd0);
            end else if (armed) begin
                idle <= idle + 1;
                if (idle + 1 == int'(period) * `WDOG_TICK) tmo <= 1'b1;  // bus idle too long
            end
        end
    end

    // ------------------------------------------------------------------------
    // compare on the falling edge, where every output is settled
    // ------------------------------------------------------------------------
    always @(negedge sysclk) begin
        if (rst_n) begin
            check("reg_raddr", 32'(exp_raddr), 32'(reg_raddr));
            check("reg_waddr", 32'(host_waddr), 32'(reg_waddr));
            check("reg_wdata", host_wdata, reg_wdata);
            check("reg_wen", 32'(host_wen), 32'(reg_wen));
            check("blk_wen", 32'(host_blk_wen), 32'(blk_wen));
            check("blk_wstart", 32'(host_blk_wstart), 32'(blk_wstart));
            if (exp_raddr[15:12] == `ADDR_HUB) begin
                // hub data counts only once the address has been held an edge
                if (raddr_q == exp_raddr && !$isunknown(hub_q)) begin
                    check("reg_rdata", hub_q | reg_rdata_ext, reg_rdata);
                end
                check("reg_rwait", 32'(1'b1), 32'(reg_rwait));
            end else begin
                if (exp_raddr[15:12] == `ADDR_MAIN && exp_raddr[7:4] == 4'd0) begin
                    check("reg_rdata", regs_value(exp_raddr) | reg_rdata_ext, reg_rdata);
                end else begin
                    check("reg_rdata", reg_rdata_ext, reg_rdata);   // unmapped reads 0
                end
                check("reg_rwait", 32'(reg_rwait_ext), 32'(reg_rwait));
            end
            check("hub_seq", 32'(seq), 32'(hub_seq));
            check("wdog_timeout", 32'(tmo), 32'(wdog_timeout));
            check("wdog_period_led", 32'(period != 16'd0), 32'(wdog_period_led));
            check("wdog_period_status", 32'(status_of(period)), 32'(wdog_period_status));
            if (wdog_timeout && !tmo_q) fires++;
            tmo_q = wdog_timeout;
        end
        if (done && !done_seen) begin
            done_seen = 1'b1;
            if (fires == 0) begin
                err_cnt++;
                $display("the watchdog timeout never fired during the run");
            end
        end
    end

endmodule

// ==== sim/tb_board_core.sv ====
// testbench for the register-bus core
// builds a stimulus table, applies it step by step, limits the run length
// and prints the closing summary; board_checker does the comparing

`timescale 1ns/1ps
`include "board_config.svh"

module tb_board_core;
    import board_pkg::*;

    typedef enum int {OP_WR, OP_RD, OP_RT, OP_WAIT, OP_CLR} op_t;

    typedef struct packed {
        op_t       op;
        reg_addr_t addr;
        reg_data_t data;
        reg_data_t ext;     // external read data whose bit 31 also raises the wait
        int        exp;     // cycles to wait for the watchdog to fire
    } step_t;

    localparam reg_addr_t STATUS_ADDR  = {`ADDR_MAIN, 8'h00, `REG_STATUS};
    localparam reg_addr_t VERSION_ADDR = {`ADDR_MAIN, 8'h00, `REG_VERSION};
    localparam reg_addr_t WDOG_ADDR    = {`ADDR_MAIN, 8'h00, `REG_WDOG};
    localparam reg_addr_t SEQ_ADDR     = {`ADDR_HUB, `HUB_SEQ_OFFSET};

    logic        sysclk;
    logic        rst_n;
    board_id_t   board_id;
    reg_addr_t   host_raddr;
    reg_addr_t   host_waddr;
    reg_addr_t   reg_raddr;
    reg_addr_t   reg_waddr;
    reg_data_t   host_wdata;
    reg_data_t   reg_wdata;
    reg_data_t   reg_rdata_ext;
    reg_data_t   reg_rdata;
    logic        host_blk_rt_rd;
    logic        host_wen;
    logic        host_blk_wen;
    logic        host_blk_wstart;
    logic        reg_wen;
    logic        blk_wen;
    logic        blk_wstart;
    logic        reg_rwait_ext;
    logic        reg_rwait;
    logic        wdog_clear;
    logic        wdog_period_led;
    logic        wdog_timeout;
    logic [15:0] hub_seq;
    logic [2:0]  wdog_period_status;
    logic        done = 1'b0;
    int          errors;

    step_t table_q [$];
    int    max_period = 0;
    int    limit      = 0;      // 0 until the table is built
    int    cycles     = 0;

    board_core dut (.*);

    board_checker chk (.*);

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    // cycle limit from table length and the longest watchdog period
    always @(posedge sysclk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("run stopped, cycle limit of %0d reached before the table ended", limit);
            $display("tb_board_core: %0d errors", errors);
            $display("Errors found");
            $finish;
        end
    end

    task automatic add_step(input op_t op, input reg_addr_t addr, input reg_data_t data,
                            input reg_data_t ext, input int exp);
        step_t s;
        s = '{op, addr, data, ext, exp};
        table_q.push_back(s);
        if (op == OP_WR && addr == WDOG_ADDR && int'(data[15:0]) > max_period) begin
            max_period = int'(data[15:0]);
        end
    endtask

    // drives one table entry 1 ns after the edge and holds strobes for one cycle
    task automatic apply_step(input step_t s);
        int n;
        n = 0;
        @(posedge sysclk);
        #1;
        case (s.op)
            OP_WR: begin
                host_waddr      = s.data == s.data ? s.addr : s.addr;
                host_wdata      = s.data;
                host_wen        = 1'b1;
                host_blk_wen    = s.data[0];    // block strobes follow the low data bits
                host_blk_wstart = s.data[1];
            end
            OP_RD, OP_RT: begin
                host_raddr     = s.addr;
                host_blk_rt_rd = (s.op == OP_RT);
                reg_rdata_ext  = s.ext;
                reg_rwait_ext  = s.ext[31];
            end
            OP_CLR:  wdog_clear = 1'b1;
            default: ;
        endcase
        @(posedge sysclk);
        #1;
        host_wen        = 1'b0;
        host_blk_wen    = 1'b0;
        host_blk_wstart = 1'b0;
        wdog_clear      = 1'b0;
        if (s.op == OP_WAIT) begin
            while (!wdog_timeout && n < s.exp + 2) begin
                @(posedge sysclk);
                #1;
                n++;
            end
        end else if (s.op == OP_RD || s.op == OP_RT) begin
            @(posedge sysclk);                  // hold the address one more edge
            #1;
            host_blk_rt_rd = 1'b0;
            reg_rdata_ext  = '0;
            reg_rwait_ext  = 1'b0;
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        board_id        = 4'ha;
        host_raddr      = '0;
        host_waddr      = '0;
        host_wdata      = '0;
        host_blk_rt_rd  = 1'b0;
        host_wen        = 1'b0;
        host_blk_wen    = 1'b0;
        host_blk_wstart = 1'b0;
        reg_rdata_ext   = '0;
        reg_rwait_ext   = 1'b0;
        wdog_clear      = 1'b0;
        void'($urandom(32'h0ad0_dd76));

        // board registers while the period is still 0
        add_step(OP_RD, VERSION_ADDR, 32'd0, 32'd0, 0);
        add_step(OP_RD, STATUS_ADDR, 32'd0, 32'd0, 0);
        add_step(OP_RD, WDOG_ADDR, 32'd0, 32'd0, 0);
        add_step(OP_WR, WDOG_ADDR, 32'h0000_0100, 32'd0, 0);    // led status clamps to 7
        add_step(OP_RD, WDOG_ADDR, 32'd0, 32'd0, 0);
        add_step(OP_WR, WDOG_ADDR, 32'h0000_0060, 32'd0, 0);
        add_step(OP_RD, WDOG_ADDR, 32'd0, 32'd0, 0);
        // hub writes at a stride of 13 so some addresses wrap past the depth
        for (int i = 0; i < 8; i++) begin
            add_step(OP_WR, {`ADDR_HUB, 12'(i * 13)}, $urandom(), 32'd0, 0);
        end
        add_step(OP_WR, SEQ_ADDR, $urandom(), 32'd0, 0);
        for (int i = 0; i < 8; i++) begin
            add_step(OP_RD, {`ADDR_HUB, 12'(i * 13)}, 32'd0, 32'd0, 0);
        end
        add_step(OP_RD, SEQ_ADDR, 32'd0, 32'd0, 0);
        // real-time block read up to one index past the end
        for (int i = 0; i <= `NUM_RT_READ_QUADS; i++) begin
            add_step(OP_RT, 16'(i), 32'd0, 32'd0, 0);
        end
        // routing with external data merged in
        add_step(OP_RD, VERSION_ADDR, 32'd0, $urandom(), 0);
        add_step(OP_RD, {`ADDR_HUB, 12'd13}, 32'd0, $urandom(), 0);
        add_step(OP_RD, 16'h1234, 32'd0, $urandom(), 0);
        add_step(OP_RD, 16'h0050, 32'd0, 32'd0, 0);             // unmapped channel 5
        add_step(OP_RD, 16'h0050, 32'd0, 32'h8000_0000, 0);     // external wait alone
        add_step(OP_RD, 16'h7000, 32'd0, 32'd0, 0);
        // watchdog fires and is cleared, then a write pushes the next timeout out
        add_step(OP_WR, WDOG_ADDR, 32'd3, 32'd0, 0);
        add_step(OP_WAIT, '0, 32'd0, 32'd0, 3 * `WDOG_TICK);
        add_step(OP_RD, STATUS_ADDR, 32'd0, 32'd0, 0);
        add_step(OP_CLR, '0, 32'd0, 32'd0, 0);
        add_step(OP_WAIT, '0, 32'd0, 32'd0, 20);
        add_step(OP_WR, {`ADDR_HUB, 12'd5}, $urandom(), 32'd0, 0);
        add_step(OP_WAIT, '0, 32'd0, 32'd0, 3 * `WDOG_TICK);
        add_step(OP_WR, STATUS_ADDR, 32'd1, 32'd0, 0);          // clear by status write
        add_step(OP_WR, WDOG_ADDR, 32'd0, 32'd0, 0);
        add_step(OP_RD, WDOG_ADDR, 32'd0, 32'd0, 0);
        limit = table_q.size() * 4 + max_period * `WDOG_TICK + 200;

        repeat (16) @(posedge sysclk);
        #1;
        rst_n = 1'b1;
        foreach (table_q[i]) begin
            apply_step(table_q[i]);
        end
        done = 1'b1;
        repeat (2) @(posedge sysclk);
        $display("tb_board_core: %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
design/board_pkg.sv
design/rt_read_xlate.sv
design/hub_mem.sv
design/board_regs.sv
design/read_route.sv
design/board_core.sv
sim/board_checker.sv
sim/tb_board_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the board_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_board_core -o tb_board_core \
    && ./obj_dir/tb_board_core > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "FAILED"; exit 1; } || { echo "PASSED"; exit 0; }
